// File: hw/prefix_pkg.sv
//**************************************************************************
// Shared constants and types for the neural prefix recognizer.
// Every RTL block and the testbench refer to these by scoped names.
//**************************************************************************

`default_nettype none

package prefix_pkg;

  localparam int num_neurons    = 64;
  localparam int max_features   = 8;
  localparam int feat_width     = 8;
  localparam int acc_width      = 20;
  localparam int act_shift      = 4;
  localparam int num_candidates = 8;

  typedef logic [5:0] neuron_idx_t;
  typedef logic [2:0] feat_idx_t;

  // One neuron's score while it travels through the comparison tree.
  typedef struct packed {
    neuron_idx_t                   index;
    logic signed [feat_width-1:0]  value;
  } neuron_score_t;

  // Element slices are raw two's complement bytes.
  typedef logic [num_neurons-1:0][feat_width-1:0] act_vec_t;
  typedef logic [num_neurons-1:0][feat_width-1:0] weight_col_t;

  typedef struct packed {
    logic                          en;
    neuron_idx_t                   neuron;
    feat_idx_t                     feature;
    logic signed [feat_width-1:0]  data;
  } weight_wr_t;

  typedef struct packed {
    logic                          valid;
    logic                          last;
    logic signed [feat_width-1:0]  data;
  } feature_beat_t;

  // Held constant from a record's first feature until its result appears.
  typedef struct packed {
    logic [num_neurons-1:0]        neuron_en;
    logic signed [feat_width-1:0]  threshold;
  } prefix_cfg_t;

  typedef struct packed {
    logic                          valid;
    neuron_idx_t                   prefix;
    logic signed [feat_width-1:0]  score;
  } prefix_result_t;

  typedef enum logic {
    st_idle,
    st_accum
  } seq_state_t;

endpackage

`default_nettype wire

// File: hw/prefix_weight_mem.sv
//**************************************************************************
// Weight storage for all neurons, one signed byte per neuron and feature.
// Writes land at the sampling edge; the read returns a whole feature
// column without delay so it lines up with the incoming beat.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module prefix_weight_mem (
  input  logic                    clk,
  input  logic                    rst_n,
  input  prefix_pkg::weight_wr_t  wr,
  input  prefix_pkg::feat_idx_t   feat_idx,
  output prefix_pkg::weight_col_t col
);

  // One row per feature position, each row a full column of weights.
  prefix_pkg::weight_col_t mem [prefix_pkg::max_features];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int f = 0; f < prefix_pkg::max_features; f++) begin
        mem[f] <= '0;
      end
    end else if (wr.en) begin
      mem[wr.feature][wr.neuron] <= wr.data;
    end
  end

  // The sequencer presents the position of the beat on the bus now.
  always_comb begin
    col = mem[feat_idx];
  end

endmodule

`default_nettype wire

// File: hw/prefix_seq.sv
//**************************************************************************
// Record sequencer. Tracks the feature position inside a record, flags
// the first beat so the accumulators reload, and raises score_valid in
// the cycle after the closing beat.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module prefix_seq (
  input  logic                      clk,
  input  logic                      rst_n,
  input  prefix_pkg::feature_beat_t beat,
  output prefix_pkg::feat_idx_t     feat_idx,
  output logic                      first,
  output logic                      score_valid
);

  prefix_pkg::seq_state_t state;
  prefix_pkg::feat_idx_t  cnt;
  logic                   closing;

  // A record closes on last, or is cut off on its eighth beat.
  always_comb begin
    closing = beat.last || (cnt == prefix_pkg::feat_idx_t'(prefix_pkg::max_features - 1));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= prefix_pkg::st_idle;
      cnt         <= '0;
      score_valid <= 1'b0;
    end else begin
      score_valid <= beat.valid && closing;
      if (beat.valid) begin
        if (closing) begin
          state <= prefix_pkg::st_idle;
          cnt   <= '0;
        end else begin
          state <= prefix_pkg::st_accum;
          cnt   <= cnt + prefix_pkg::feat_idx_t'(1);
        end
      end
    end
  end

  // The counter is already zero in st_idle, so it can drive the read directly.
  assign feat_idx = cnt;
  assign first    = beat.valid && (state == prefix_pkg::st_idle);

endmodule

`default_nettype wire

// File: hw/prefix_neuron_array.sv
//**************************************************************************
// Sixty-four multiply-accumulate neurons. Each valid beat multiplies the
// feature by every neuron's weight; the first beat of a record reloads
// the sums. Activations are the sums scaled down and clipped to a byte.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module prefix_neuron_array (
  input  logic                      clk,
  input  logic                      rst_n,
  input  prefix_pkg::feature_beat_t beat,
  input  logic                      first,
  input  prefix_pkg::weight_col_t   col,
  output prefix_pkg::act_vec_t      act
);

  logic signed [prefix_pkg::acc_width-1:0]    acc  [prefix_pkg::num_neurons];
  logic signed [2*prefix_pkg::feat_width-1:0] prod [prefix_pkg::num_neurons];

  // Arithmetic shift, then clip to the signed byte range.
  function automatic logic [prefix_pkg::feat_width-1:0] activate(
    input logic signed [prefix_pkg::acc_width-1:0] sum
  );
    logic signed [prefix_pkg::acc_width-1:0] scaled;
    scaled = sum >>> prefix_pkg::act_shift;
    if (scaled > 127) begin
      activate = 8'h7f;
    end else if (scaled < -128) begin
      activate = 8'h80;
    end else begin
      activate = scaled[prefix_pkg::feat_width-1:0];
    end
  endfunction

  always_comb begin
    for (int n = 0; n < prefix_pkg::num_neurons; n++) begin
      prod[n] = beat.data * $signed(col[n]);
    end
  end

  // Eight full-scale products fit easily in twenty bits, so no wrap occurs.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int n = 0; n < prefix_pkg::num_neurons; n++) begin
        acc[n] <= '0;
      end
    end else if (beat.valid) begin
      for (int n = 0; n < prefix_pkg::num_neurons; n++) begin
        if (first) begin
          acc[n] <= prefix_pkg::acc_width'(prod[n]);
        end else begin
          acc[n] <= acc[n] + prefix_pkg::acc_width'(prod[n]);
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < prefix_pkg::num_neurons; n++) begin
      act[n] = activate(acc[n]);
    end
  end

endmodule

`default_nettype wire

// File: hw/prefix_argmax.sv
//**************************************************************************
// Output stage. Masks disabled neurons, finds the strongest one with a
// two-stage comparison tree and applies the threshold. Stage one keeps
// eight group winners, stage two the overall winner and the decision.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module prefix_argmax (
  input  logic                    clk,
  input  logic                    rst_n,
  input  prefix_pkg::act_vec_t    act,
  input  logic                    score_valid,
  input  prefix_pkg::prefix_cfg_t cfg,
  output logic [prefix_pkg::num_candidates-1:0][prefix_pkg::feat_width-1:0] candidates,
  output prefix_pkg::prefix_result_t result
);

  prefix_pkg::neuron_score_t lvl64  [prefix_pkg::num_neurons];
  prefix_pkg::neuron_score_t lvl32  [32];
  prefix_pkg::neuron_score_t lvl16  [16];
  prefix_pkg::neuron_score_t lvl8   [prefix_pkg::num_candidates];
  prefix_pkg::neuron_score_t stage1 [prefix_pkg::num_candidates];
  prefix_pkg::neuron_score_t lvl4   [4];
  prefix_pkg::neuron_score_t lvl2   [2];
  prefix_pkg::neuron_score_t winner;
  logic                      stage1_valid;

  // The higher index wins only when strictly greater, so ties keep the lower.
  function automatic prefix_pkg::neuron_score_t pick(
    input prefix_pkg::neuron_score_t lo,
    input prefix_pkg::neuron_score_t hi
  );
    return (hi.value > lo.value) ? hi : lo;
  endfunction

  always_comb begin
    for (int n = 0; n < prefix_pkg::num_neurons; n++) begin
      lvl64[n].index = prefix_pkg::neuron_idx_t'(n);
      // A disabled neuron sits at the most negative activation.
      lvl64[n].value = cfg.neuron_en[n] ? $signed(act[n]) : 8'sh80;
    end
    for (int i = 0; i < 32; i++) lvl32[i] = pick(lvl64[2*i], lvl64[2*i+1]);
    for (int i = 0; i < 16; i++) lvl16[i] = pick(lvl32[2*i], lvl32[2*i+1]);
    for (int i = 0; i < 8; i++) lvl8[i] = pick(lvl16[2*i], lvl16[2*i+1]);
  end

  always_comb begin
    for (int i = 0; i < 4; i++) lvl4[i] = pick(stage1[2*i], stage1[2*i+1]);
    for (int i = 0; i < 2; i++) lvl2[i] = pick(lvl4[2*i], lvl4[2*i+1]);
    winner = pick(lvl2[0], lvl2[1]);
  end

  // Stage one only loads final sums, so a new record cannot disturb it early.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < prefix_pkg::num_candidates; i++) begin
        stage1[i] <= '0;
      end
      stage1_valid <= 1'b0;
    end else begin
      stage1_valid <= score_valid;
      if (score_valid) begin
        stage1 <= lvl8;
      end
    end
  end

  // Candidates are copied with the result so both describe the same record.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result     <= '0;
      candidates <= '0;
    end else begin
      result.valid <= stage1_valid;
      if (stage1_valid) begin
        result.score <= winner.value;
        result.prefix <= (winner.value >= cfg.threshold) ? winner.index : '0;
        for (int i = 0; i < prefix_pkg::num_candidates; i++) begin
          candidates[i] <= stage1[i].value;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/prefix_recognizer.sv
//**************************************************************************
// Top level of the prefix recognizer. Features enter one per clock, and
// the winning prefix appears two edges after the record's closing beat.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module prefix_recognizer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  prefix_pkg::feature_beat_t beat,
  input  prefix_pkg::weight_wr_t    wr,
  input  prefix_pkg::prefix_cfg_t   cfg,
  output logic [prefix_pkg::num_candidates-1:0][prefix_pkg::feat_width-1:0] candidates,
  output prefix_pkg::prefix_result_t result
);

  prefix_pkg::feat_idx_t   feat_idx;
  logic                    first;
  logic                    score_valid;
  prefix_pkg::weight_col_t col;
  prefix_pkg::act_vec_t    act;

  prefix_weight_mem u_weight_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .feat_idx (feat_idx),
    .col      (col)
  );

  prefix_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat        (beat),
    .feat_idx    (feat_idx),
    .first       (first),
    .score_valid (score_valid)
  );

  prefix_neuron_array u_neuron_array (
    .clk   (clk),
    .rst_n (rst_n),
    .beat  (beat),
    .first (first),
    .col   (col),
    .act   (act)
  );

  // The configuration goes only to the output stage.
  prefix_argmax u_argmax (
    .clk         (clk),
    .rst_n       (rst_n),
    .act         (act),
    .score_valid (score_valid),
    .cfg         (cfg),
    .candidates  (candidates),
    .result      (result)
  );

endmodule

`default_nettype wire

// File: bench/prefix_recognizer_props.sv
//**************************************************************************
// Protocol assertions for the prefix recognizer, bound into the top level.
// They watch result spacing, weight writes and start-up behavior.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module prefix_recognizer_props (
  input logic clk,
  input logic rst_n,
  input logic beat_valid,
  input logic wr_en,
  input logic score_valid,
  input logic result_valid
);

  logic beat_seen;

  // Goes high with the first accepted beat after reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_seen <= 1'b0;
    end else if (beat_valid) begin
      beat_seen <= 1'b1;
    end
  end

  // Back-to-back results need two closing beats in a row.
  a_result_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    (result_valid && $past(result_valid)) |-> ($past(score_valid, 2) && $past(score_valid, 3)))
    else $error("result.valid repeated without two consecutive score_valid cycles");

  a_write_no_beat: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_en && beat_valid))
    else $error("weight write coincides with a valid feature beat");

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !beat_seen |-> !result_valid)
    else $error("result.valid high before any beat was accepted");

endmodule

bind prefix_recognizer prefix_recognizer_props u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .beat_valid   (beat.valid),
  .wr_en        (wr.en),
  .score_valid  (score_valid),
  .result_valid (result.valid)
);

`default_nettype wire

// File: bench/prefix_recognizer_tb.sv
//**************************************************************************
// Testbench for the prefix recognizer. Sends random records from a fixed
// seed, predicts each result with a behavioral model and checks prefix,
// score and candidates whenever result.valid is high.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module prefix_recognizer_tb;

  localparam int clk_period  = 100;
  localparam int num_records = 272;
  localparam int num_groups  = 28;
  localparam int load_cycles = 2 * (prefix_pkg::num_neurons * prefix_pkg::max_features + 2);
  localparam int timeout_cycles =
    num_records * (prefix_pkg::max_features + 4) + load_cycles + num_groups * 8 + 100;

  logic                       clk;
  logic                       rst_n;
  prefix_pkg::feature_beat_t  beat;
  prefix_pkg::weight_wr_t     wr;
  prefix_pkg::prefix_cfg_t    cfg;
  logic [prefix_pkg::num_candidates-1:0][prefix_pkg::feat_width-1:0] candidates;
  prefix_pkg::prefix_result_t result;

  // The model keeps its own weights, the live configuration and a feature buffer.
  int          w_model [prefix_pkg::num_neurons][prefix_pkg::max_features];
  int          feat_buf [prefix_pkg::max_features];
  logic [63:0] cfg_en_model;
  int          cfg_thr_model;

  logic [5:0]  exp_prefix_q [$];
  logic [7:0]  exp_score_q [$];
  logic [63:0] exp_cand_q [$];

  integer seed = 71;
  int     errors = 0;
  int     checks = 0;
  int     records_sent = 0;
  int     results_seen = 0;

  prefix_recognizer uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .beat       (beat),
    .wr         (wr),
    .cfg        (cfg),
    .candidates (candidates),
    .result     (result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Predicts one record from the buffered features and queues the result.
  task automatic compute_expected(input int len);
    int          acc;
    int          act;
    int          masked [prefix_pkg::num_neurons];
    int          best;
    int          best_idx;
    int          gmax;
    logic [63:0] cand;
    for (int n = 0; n < prefix_pkg::num_neurons; n++) begin
      acc = 0;
      for (int f = 0; f < len; f++) begin
        acc += feat_buf[f] * w_model[n][f];
      end
      act = acc >>> prefix_pkg::act_shift;
      if (act > 127) begin
        act = 127;
      end else if (act < -128) begin
        act = -128;
      end
      masked[n] = cfg_en_model[n] ? act : -128;
    end
    best = masked[0];
    best_idx = 0;
    for (int n = 1; n < prefix_pkg::num_neurons; n++) begin
      if (masked[n] > best) begin
        best = masked[n];
        best_idx = n;
      end
    end
    cand = '0;
    for (int g = 0; g < prefix_pkg::num_candidates; g++) begin
      gmax = masked[8*g];
      for (int j = 1; j < 8; j++) begin
        if (masked[8*g+j] > gmax) begin
          gmax = masked[8*g+j];
        end
      end
      cand[8*g +: 8] = 8'(gmax);
    end
    exp_prefix_q.push_back((best >= cfg_thr_model) ? 6'(best_idx) : 6'd0);
    exp_score_q.push_back(8'(best));
    exp_cand_q.push_back(cand);
  endtask

  // Saturating weights give many identical neurons, so ties are common.
  task automatic load_weights(input bit saturating);
    int data;
    for (int f = 0; f < prefix_pkg::max_features; f++) begin
      for (int n = 0; n < prefix_pkg::num_neurons; n++) begin
        if (!saturating) begin
          data = ($random(seed) & 255) - 128;
        end else if (n % 4 == 1) begin
          data = -128;
        end else if (n % 4 == 3) begin
          data = ($random(seed) & 15) - 8;
        end else begin
          data = 127;
        end
        w_model[n][f] = data;
        @(posedge clk);
        wr.en      <= 1'b1;
        wr.neuron  <= 6'(n);
        wr.feature <= 3'(f);
        wr.data    <= 8'(data);
      end
    end
    @(posedge clk);
    wr.en <= 1'b0;
  endtask

  task automatic apply_cfg(input logic [63:0] en, input int thr);
    cfg_en_model  = en;
    cfg_thr_model = thr;
    @(posedge clk);
    cfg.neuron_en <= en;
    cfg.threshold <= 8'(thr);
  endtask

  task automatic wait_drained();
    while (exp_prefix_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  // Records go out back-to-back; an eight-beat record may leave last low.
  task automatic send_group(input int count);
    int len;
    for (int r = 0; r < count; r++) begin
      len = 1 + ($random(seed) & 7);
      for (int f = 0; f < len; f++) begin
        feat_buf[f] = ($random(seed) & 255) - 128;
        @(posedge clk);
        beat.valid <= 1'b1;
        beat.data  <= 8'(feat_buf[f]);
        beat.last  <= (f == len - 1) && ((len < 8) || (($random(seed) & 1) == 1));
      end
      compute_expected(len);
      records_sent++;
    end
    @(posedge clk);
    beat.valid <= 1'b0;
    beat.last  <= 1'b0;
    wait_drained();
  endtask

  // Outputs are read on the falling edge, away from the updates.
  always @(negedge clk) begin
    if (rst_n && result.valid) begin
      results_seen++;
      if (exp_prefix_q.size() == 0) begin
        errors++;
        $display("result.valid was high with no record waiting for a result");
      end else begin
        check_value("result.prefix", {58'b0, result.prefix}, {58'b0, exp_prefix_q.pop_front()});
        check_value("result.score", {56'b0, result.score}, {56'b0, exp_score_q.pop_front()});
        check_value("candidates", candidates, exp_cand_q.pop_front());
      end
    end
  end

  initial begin
    beat  <= '0;
    wr    <= '0;
    cfg   <= '{neuron_en: '1, threshold: 8'sh80};
    rst_n <= 1'b0;
    cfg_en_model  = '1;
    cfg_thr_model = -128;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    load_weights(1'b0);
    apply_cfg('1, -128);
    send_group(40);
    // The masks go all off first, then single neurons, then random sets.
    for (int g = 0; g < 12; g++) begin
      if (g == 0) begin
        apply_cfg('0, -128);
      end else if (g < 5) begin
        apply_cfg(64'd1 << ($random(seed) & 63), -128);
      end else begin
        apply_cfg({$random(seed), $random(seed)}, -128);
      end
      send_group(6);
    end
    for (int g = 0; g < 10; g++) begin
      apply_cfg((g % 2 == 0) ? '1 : {$random(seed), $random(seed)},
                ($random(seed) & 255) - 128);
      send_group(6);
    end
    apply_cfg('1, -128);
    send_group(60);

    load_weights(1'b1);
    for (int g = 0; g < 4; g++) begin
      apply_cfg((g == 0) ? '1 : {$random(seed), $random(seed)}, -128);
      send_group(10);
    end

    if (results_seen != records_sent) begin
      errors++;
      $display("%0d records were sent but %0d results arrived", records_sent, results_seen);
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("run timed out after %0d clock cycles", timeout_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/prefix_pkg.sv
hw/prefix_weight_mem.sv
hw/prefix_seq.sv
hw/prefix_neuron_array.sv
hw/prefix_argmax.sv
hw/prefix_recognizer.sv
bench/prefix_recognizer_props.sv
bench/prefix_recognizer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the prefix recognizer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module prefix_recognizer_tb \
  -f vlog.f \
  --Mdir obj_dir -o prefix_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/prefix_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
if grep -q "all tests passed" sim.log; then
  exit 0
fi
echo "simulation log holds no final verdict"
exit 1
